/* dv/sdramModel.sv */
// behavioral SDRAM model: decodes pin commands, stores words, logs the init and refresh order
`timescale 1ns/1ns

module sdramModel (
	input logic Clock,
	input logic SDram_CKE_H,
	input logic SDram_CS_L,
	input logic SDram_RAS_L,
	input logic SDram_CAS_L,
	input logic SDram_WE_L,
	input sdramPkg::rowAddrT SDram_Addr,
	input sdramPkg::bankT SDram_BA,
	inout wire sdramPkg::wordT SDram_DQ
);

	sdramPkg::wordT mem [int];			// sparse storage, key is bank, row, column
	sdramPkg::rowAddrT openRow [4];
	sdramPkg::sdramCmdE cmd;
	logic readPend;						// read seen, data goes out next cycle
	int readKey;
	logic dqDrive;
	sdramPkg::wordT dqData;

	// observation for the testbench
	logic preAllSeen;					// precharge all during init
	logic modeSeen;
	logic modeOk;						// mode word matched
	logic earlyAccess;					// read or write before mode set
	logic prechargeArmed;				// precharge all since last activate
	int initRefs;
	int refreshCount;
	int badRefresh;
	int busyCount;						// activate, read, write, refresh after init
	sdramPkg::bankT lastActBank;
	sdramPkg::rowAddrT lastActRow;
	sdramPkg::bankT lastBank;
	sdramPkg::rowAddrT lastColAddr;

	function automatic int keyOf(sdramPkg::bankT b, sdramPkg::rowAddrT r, logic [9:0] c);
		return {7'b0, b, r, c};
	endfunction

	assign cmd = sdramPkg::sdramCmdE'({SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L});
	assign SDram_DQ = dqDrive ? dqData : 'z;

	initial
	begin
		readPend = 1'b0;
		readKey = 0;
		dqDrive = 1'b0;
		dqData = '0;
		preAllSeen = 1'b0;
		modeSeen = 1'b0;
		modeOk = 1'b0;
		earlyAccess = 1'b0;
		prechargeArmed = 1'b0;
		initRefs = 0;
		refreshCount = 0;
		badRefresh = 0;
		busyCount = 0;
	end

	////////////////////////////////////////////////////////////////////////////
	// command decode, CAS latency 2 seen from the pins
	////////////////////////////////////////////////////////////////////////////

	always @(posedge Clock)
	begin
		dqDrive <= readPend;						// valid for the mid cycle capture
		if (readPend)
			dqData <= mem.exists(readKey) ? mem[readKey] : '0;
		readPend <= 1'b0;
		if (SDram_CKE_H)
			case (cmd)
				sdramPkg::activate:
				begin
					openRow[SDram_BA] <= SDram_Addr;
					lastActBank <= SDram_BA;
					lastActRow <= SDram_Addr;
					prechargeArmed <= 1'b0;
					if (modeSeen)
						busyCount <= busyCount + 1;
				end
				sdramPkg::read:
				begin
					readPend <= 1'b1;
					readKey <= keyOf(SDram_BA, openRow[SDram_BA], SDram_Addr[9:0]);
					lastBank <= SDram_BA;
					lastColAddr <= SDram_Addr;
					earlyAccess <= earlyAccess || !modeSeen;
					busyCount <= busyCount + 1;
				end
				sdramPkg::write:
				begin
					mem[keyOf(SDram_BA, openRow[SDram_BA], SDram_Addr[9:0])] = SDram_DQ;
					lastBank <= SDram_BA;
					lastColAddr <= SDram_Addr;
					earlyAccess <= earlyAccess || !modeSeen;
					busyCount <= busyCount + 1;
				end
				sdramPkg::precharge:
					if (SDram_Addr[10])
					begin
						prechargeArmed <= 1'b1;
						if (!modeSeen)
							preAllSeen <= 1'b1;
					end
				sdramPkg::autoRefresh:
					if (modeSeen)
					begin
						refreshCount <= refreshCount + 1;
						busyCount <= busyCount + 1;
						if (!prechargeArmed)
							badRefresh <= badRefresh + 1;	// refresh with a row possibly open
						prechargeArmed <= 1'b0;
					end
					else if (preAllSeen)
						initRefs <= initRefs + 1;
				sdramPkg::modeSet:
				begin
					modeSeen <= 1'b1;
					modeOk <= preAllSeen && (SDram_Addr == sdramPkg::modeWord);
				end
				default:
					;										// nop and deselect
			endcase
	end

endmodule

/* dv/sdramStim.txt */
# op address write-data expected-read-data hold-cycles (hex, hex, hex, decimal)
# op is w or r, expected is ignored for writes, hold keeps the strobes low after Dtack_L
w 00000010 1234 0000 0
w 01000abc 5678 0000 0
w 02fff802 9abc 0000 0
w 03123456 cafe 0000 0
w 00800020 beef 0000 0
r 00000010 0000 1234 0
r 01000abc 0000 5678 0
r 02fff802 0000 9abc 0
r 03123456 0000 cafe 0
r 00800020 0000 beef 0
w 00000010 4321 0000 0
r 00000010 0000 4321 10
w 01fff7fe 0f0f 0000 0
r 01fff7fe 0000 0f0f 0

/* dv/tbSdramController.sv */
// SDRAM controller testbench covering init order, read/write, mapping, refresh and back-pressure
`timescale 1ns/1ns

module tbSdramController;

	localparam sdramPkg::delayT PowerUpCycles = 16'd8;
	localparam logic [3:0] InitRefreshes = 4'd2;
	localparam sdramPkg::delayT RefreshInterval = 16'd60;
	localparam logic [1:0] CasLatency = 2'd2;

	logic Clock;
	logic Reset_L;
	sdramPkg::cpuAddrT Address;
	sdramPkg::wordT DataIn;
	logic UDS_L;
	logic LDS_L;
	logic DramSelect_L;
	logic WE_L;
	logic AS_L;
	sdramPkg::wordT DataOut;
	logic SDram_CKE_H;
	logic SDram_CS_L;
	logic SDram_RAS_L;
	logic SDram_CAS_L;
	logic SDram_WE_L;
	sdramPkg::rowAddrT SDram_Addr;
	sdramPkg::bankT SDram_BA;
	wire sdramPkg::wordT SDram_DQ;
	logic Dtack_L;
	logic ResetOut_L;

	byte opQ[$];					// stim columns with one entry per line
	sdramPkg::cpuAddrT addrQ[$];
	sdramPkg::wordT dataQ[$];
	sdramPkg::wordT expQ[$];
	int holdQ[$];
	logic stimLoaded;
	int errorCount;
	int testCount;
	int failedTests;

	sdramController #(.PowerUpCycles(PowerUpCycles), .InitRefreshes(InitRefreshes),
		.RefreshInterval(RefreshInterval), .CasLatency(CasLatency)) dut0 (
		.Clock(Clock), .Reset_L(Reset_L), .Address(Address), .DataIn(DataIn),
		.UDS_L(UDS_L), .LDS_L(LDS_L), .DramSelect_L(DramSelect_L), .WE_L(WE_L), .AS_L(AS_L),
		.DataOut(DataOut), .SDram_CKE_H(SDram_CKE_H), .SDram_CS_L(SDram_CS_L),
		.SDram_RAS_L(SDram_RAS_L), .SDram_CAS_L(SDram_CAS_L), .SDram_WE_L(SDram_WE_L),
		.SDram_Addr(SDram_Addr), .SDram_BA(SDram_BA), .SDram_DQ(SDram_DQ),
		.Dtack_L(Dtack_L), .ResetOut_L(ResetOut_L));

	sdramModel model0 (
		.Clock(Clock), .SDram_CKE_H(SDram_CKE_H), .SDram_CS_L(SDram_CS_L),
		.SDram_RAS_L(SDram_RAS_L), .SDram_CAS_L(SDram_CAS_L), .SDram_WE_L(SDram_WE_L),
		.SDram_Addr(SDram_Addr), .SDram_BA(SDram_BA), .SDram_DQ(SDram_DQ));

	initial
	begin
		Clock = 1'b0;
		forever #2 Clock = ~Clock;
	end

	// run limit scales with the stim length plus the idle refresh window
	initial
	begin
		wait (stimLoaded);
		repeat (opQ.size() * 40 + PowerUpCycles + 200 + 3 * RefreshInterval) @(posedge Clock);
		$display("watchdog expired at %0t, run did not finish", $time);
		$display("Verification failed");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic loadStim();
		int fd;
		int n;
		string line;
		byte op;
		sdramPkg::cpuAddrT a;
		sdramPkg::wordT w;
		sdramPkg::wordT e;
		int h;
		fd = $fopen("dv/sdramStim.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open dv/sdramStim.txt");
			errorCount++;
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() == 0 || line[0] == "#")
				continue;								// header and blank lines
			n = $sscanf(line, "%c %h %h %h %d", op, a, w, e, h);
			if (n != 5)
				continue;
			opQ.push_back(op);
			addrQ.push_back(a);
			dataQ.push_back(w);
			expQ.push_back(e);
			holdQ.push_back(h);
		end
		$fclose(fd);
	endtask

	task automatic reportTest(input string name, input int startErrors);
		testCount++;
		if (errorCount == startErrors)
			$display("test %s: ok", name);
		else
		begin
			failedTests++;
			$display("test %s: FAILED", name);
		end
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			errorCount++;
		end
	endtask

	// bank 25:24, row 23:11, column 10:1, auto precharge on A10
	task automatic checkMapping(input sdramPkg::cpuAddrT addr);
		checkValue("activate bank", model0.lastActBank, addr[25:24]);
		checkValue("activate row", model0.lastActRow, addr[23:11]);
		checkValue("access bank", model0.lastBank, addr[25:24]);
		checkValue("column", model0.lastColAddr[9:0], addr[10:1]);
		checkValue("A10", model0.lastColAddr[10], 1'b1);
	endtask

	// one 68000 bus cycle
	// hold keeps the data strobes down after Dtack_L
	task automatic busCycle(input byte op, input sdramPkg::cpuAddrT addr,
		input sdramPkg::wordT wdata, input sdramPkg::wordT expData, input int hold,
		output sdramPkg::wordT rdata);
		int waitCount;
		int busyStart;
		@(posedge Clock);
		#1;
		Address = addr;
		DataIn = wdata;
		WE_L = (op == "w") ? 1'b0 : 1'b1;
		DramSelect_L = 1'b0;
		AS_L = 1'b0;
		UDS_L = 1'b0;
		LDS_L = 1'b0;
		waitCount = 0;
		@(negedge Clock);
		while (Dtack_L !== 1'b0 && waitCount < 60)
		begin
			@(negedge Clock);
			waitCount++;
		end
		if (Dtack_L !== 1'b0)
		begin
			$display("no Dtack_L for address %h at %0t", addr, $time);
			errorCount++;
		end
		rdata = DataOut;
		if (hold > 0)
		begin
			busyStart = model0.busyCount;
			repeat (hold)
			begin
				@(negedge Clock);
				checkValue("Dtack_L", Dtack_L, 1'b0);
				if (op == "r")
					checkValue("DataOut", DataOut, expData);
			end
			if (model0.busyCount != busyStart)
			begin
				$display("SDRAM got a new command while the CPU held its strobes, at %0t", $time);
				errorCount++;
			end
		end
		@(posedge Clock);
		#1;
		DramSelect_L = 1'b1;
		AS_L = 1'b1;
		UDS_L = 1'b1;
		LDS_L = 1'b1;
		WE_L = 1'b1;
		waitCount = 0;
		@(negedge Clock);
		while (Dtack_L !== 1'b1 && waitCount < 10)
		begin
			@(negedge Clock);
			waitCount++;
		end
		if (Dtack_L !== 1'b1)
		begin
			$display("Dtack_L did not rise after the strobes were released, at %0t", $time);
			errorCount++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int startErrors;
		int waitCount;
		int gap;
		int lastRefreshes;
		int startRefreshes;
		int startBad;
		sdramPkg::wordT rdata;
		Reset_L = 1'b0;
		Address = '0;
		DataIn = '0;
		UDS_L = 1'b1;
		LDS_L = 1'b1;
		DramSelect_L = 1'b1;
		WE_L = 1'b1;
		AS_L = 1'b1;
		errorCount = 0;
		testCount = 0;
		failedTests = 0;
		stimLoaded = 1'b0;
		loadStim();
		stimLoaded = 1'b1;
		repeat (2) @(posedge Clock);
		#1 Reset_L = 1'b1;

		// init order up to ResetOut_L while the CPU already asks for a read
		startErrors = errorCount;
		Address = 32'h0000_0010;
		DramSelect_L = 1'b0;
		AS_L = 1'b0;
		UDS_L = 1'b0;
		LDS_L = 1'b0;
		repeat (PowerUpCycles)
		begin
			@(negedge Clock);
			checkValue("Dtack_L", Dtack_L, 1'b1);
		end
		@(posedge Clock);
		#1;
		DramSelect_L = 1'b1;
		AS_L = 1'b1;
		UDS_L = 1'b1;
		LDS_L = 1'b1;
		waitCount = 0;
		while (ResetOut_L !== 1'b1 && waitCount < PowerUpCycles + 100)
		begin
			@(negedge Clock);
			waitCount++;
		end
		if (ResetOut_L !== 1'b1)
		begin
			$display("ResetOut_L never rose");
			errorCount++;
		end
		checkValue("precharge all seen", model0.preAllSeen, 1'b1);
		if (model0.initRefs < InitRefreshes)
		begin
			$display("only %0d init refreshes before mode set", model0.initRefs);
			errorCount++;
		end
		checkValue("mode word ok", model0.modeOk, 1'b1);
		checkValue("early access", model0.earlyAccess, 1'b0);
		reportTest("init order", startErrors);

		// write and read lines from the stim file
		for (int i = 0; i < opQ.size(); i++)
		begin
			startErrors = errorCount;
			busCycle(opQ[i], addrQ[i], dataQ[i], expQ[i], holdQ[i], rdata);
			checkMapping(addrQ[i]);
			if (opQ[i] == "r")
				checkValue("DataOut", rdata, expQ[i]);
			reportTest($sformatf("line %0d %s %h", i, (opQ[i] == "w") ? "write" : "read",
				addrQ[i]), startErrors);
		end

		// refreshes keep coming while idle
		startErrors = errorCount;
		startRefreshes = model0.refreshCount;
		lastRefreshes = startRefreshes;
		startBad = model0.badRefresh;
		gap = 0;
		repeat (3 * RefreshInterval)
		begin
			@(negedge Clock);
			gap++;
			if (model0.refreshCount != lastRefreshes)
			begin
				lastRefreshes = model0.refreshCount;
				gap = 0;
			end
			if (gap > RefreshInterval + 10)
			begin
				$display("no auto refresh for %0d cycles at %0t", gap, $time);
				errorCount++;
				gap = 0;
			end
		end
		if (model0.refreshCount - startRefreshes < 2)
		begin
			$display("too few refreshes while idle");
			errorCount++;
		end
		checkValue("refresh without precharge", model0.badRefresh, startBad);
		reportTest("idle refresh", startErrors);

		$display("tests %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
		if (failedTests == 0 && errorCount == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* files.f */
logic/sdramPkg.sv
logic/initSequencer.sv
logic/refreshTimer.sv
logic/accessFsm.sv
logic/sdramIo.sv
logic/sdramController.sv
dv/sdramModel.sv
dv/tbSdramController.sv

/* logic/accessFsm.sv */
// access FSM: idle arbitration, auto refresh and single word CPU read and write
`timescale 1ns/1ns

module accessFsm #(
	parameter logic [1:0] CasLatency = 2'd2
) (
	input logic Clock,
	input logic Reset_L,
	input logic initDone,
	input logic refreshDue,
	input sdramPkg::cpuReqT cpuReq,
	output sdramPkg::sdramCmdT accessCmd,
	output logic refreshReload,		// refresh done, restart the interval
	output logic writeEnable,		// drive DQ next cycle
	output logic readLatch,			// DQ capture window
	output logic dtack,				// acknowledge to the CPU, active high
	output sdramPkg::wordT writeData
);

	sdramPkg::accessStateE state;
	sdramPkg::accessStateE nextState;
	logic [1:0] waitCount;			// CAS latency and post refresh NOPs
	logic [1:0] waitValue;
	logic waitLoad;
	logic waitDone;
	sdramPkg::bankT bank;
	sdramPkg::rowAddrT rowAddr;
	sdramPkg::rowAddrT colAddr;

	////////////////////////////////////////////////////////////////////////////
	// CPU address split, bank 25:24, row 23:11, word column 10:1
	////////////////////////////////////////////////////////////////////////////

	assign bank = cpuReq.address[25:24];
	assign rowAddr = cpuReq.address[23:11];
	assign colAddr = {2'b00, 1'b1, cpuReq.address[10:1]};	// A10 high, auto precharge
	assign waitDone = (waitCount == '0);

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			state <= sdramPkg::accIdle;
			waitCount <= '0;
		end
		else
		begin
			state <= nextState;
			if (waitLoad)
				waitCount <= waitValue;
			else if (!waitDone)
				waitCount <= waitCount - 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// next state and command decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState = state;
		accessCmd = '{cke: 1'b1, cmd: sdramPkg::nop, bank: '0, addr: '0};
		waitLoad = 1'b0;
		waitValue = '0;
		refreshReload = 1'b0;
		writeEnable = 1'b0;
		readLatch = 1'b0;
		dtack = 1'b0;
		writeData = '0;
		case (state)
			sdramPkg::accIdle:
				if (initDone)
				begin
					if (refreshDue)							// refresh beats a waiting CPU
						nextState = sdramPkg::accRefPrecharge;
					else if (cpuReq.select && cpuReq.strobe)
					begin
						accessCmd.cmd = sdramPkg::activate;
						accessCmd.bank = bank;
						accessCmd.addr = rowAddr;
						nextState = cpuReq.write ? sdramPkg::accPreWrite : sdramPkg::accRead;
					end
				end
			sdramPkg::accRefPrecharge:
			begin
				accessCmd.cmd = sdramPkg::precharge;
				accessCmd.addr = sdramPkg::allBanks;
				nextState = sdramPkg::accRefNop;
			end
			sdramPkg::accRefNop:
				nextState = sdramPkg::accRefRefresh;
			sdramPkg::accRefRefresh:
			begin
				accessCmd.cmd = sdramPkg::autoRefresh;
				waitLoad = 1'b1;
				waitValue = 2'd2;							// three NOPs follow
				nextState = sdramPkg::accRefWait;
			end
			sdramPkg::accRefWait:
				if (waitDone)
				begin
					refreshReload = 1'b1;					// last NOP of the sequence
					nextState = sdramPkg::accIdle;
				end
			sdramPkg::accRead:
			begin
				accessCmd.cmd = sdramPkg::read;
				accessCmd.bank = bank;
				accessCmd.addr = colAddr;
				waitLoad = 1'b1;
				waitValue = CasLatency - 2'd1;
				nextState = sdramPkg::accCasWait;
			end
			sdramPkg::accCasWait:
			begin
				readLatch = 1'b1;
				if (waitDone)
					nextState = sdramPkg::accTerminate;		// data is held in DataOut
			end
			sdramPkg::accPreWrite:
				if (cpuReq.dataStrobe)						// 68000 data is valid now
				begin
					accessCmd.cmd = sdramPkg::write;
					accessCmd.bank = bank;
					accessCmd.addr = colAddr;
					writeEnable = 1'b1;
					writeData = cpuReq.dataIn;
					dtack = 1'b1;
					nextState = sdramPkg::accPostWrite;
				end
			sdramPkg::accPostWrite:
			begin
				writeEnable = 1'b1;							// hold DQ one more cycle
				writeData = cpuReq.dataIn;
				dtack = 1'b1;
				nextState = sdramPkg::accTerminate;
			end
			sdramPkg::accTerminate:
				if (cpuReq.dataStrobe)
					dtack = 1'b1;							// CPU still in its bus cycle
				else
					nextState = sdramPkg::accIdle;
			default:
				nextState = sdramPkg::accIdle;
		endcase
	end

endmodule

/* logic/initSequencer.sv */
// power-up sequencer: wait, NOP, precharge all, auto refreshes, then mode register set
`timescale 1ns/1ns

module initSequencer #(
	parameter sdramPkg::delayT PowerUpCycles = 16'd5000,
	parameter logic [3:0] InitRefreshes = 4'd8
) (
	input logic Clock,
	input logic Reset_L,
	output sdramPkg::sdramCmdT initCmd,		// command while init runs
	output logic initDone					// high for good once mode is set
);

	sdramPkg::initStateE state;
	sdramPkg::initStateE nextState;
	sdramPkg::delayT delayCount;			// general down counter, stops at 0
	sdramPkg::delayT delayValue;
	logic delayLoad;
	logic delayDone;
	logic [3:0] refreshCount;				// refreshes still to issue

	assign delayDone = (delayCount == '0);
	assign initDone = (state == sdramPkg::initComplete);

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			state <= sdramPkg::initPowerUp;
			delayCount <= '0;
			refreshCount <= '0;
		end
		else
		begin
			state <= nextState;
			if (delayLoad)
				delayCount <= delayValue;
			else if (!delayDone)
				delayCount <= delayCount - 1'b1;
			// count is armed on precharge and spent one per refresh
			if (state == sdramPkg::initPrecharge)
				refreshCount <= InitRefreshes;
			else if (state == sdramPkg::initRefresh)
				refreshCount <= refreshCount - 1'b1;
		end
	end

	always_comb
	begin
		nextState = state;
		initCmd = '{cke: 1'b1, cmd: sdramPkg::nop, bank: '0, addr: '0};
		delayLoad = 1'b0;
		delayValue = '0;
		case (state)
			sdramPkg::initPowerUp:
			begin
				initCmd = sdramPkg::powerUpCmd;
				delayLoad = 1'b1;
				delayValue = PowerUpCycles - 16'd2;	// this cycle plus the zero cycle of wait
				nextState = sdramPkg::initWait;
			end
			sdramPkg::initWait:
			begin
				initCmd = sdramPkg::powerUpCmd;		// CKE stays low until the delay runs out
				if (delayDone)
					nextState = sdramPkg::initNop;
			end
			sdramPkg::initNop:
				nextState = sdramPkg::initPrecharge;	// first valid NOP with CKE high
			sdramPkg::initPrecharge:
			begin
				initCmd.cmd = sdramPkg::precharge;
				initCmd.addr = sdramPkg::allBanks;
				nextState = sdramPkg::initRefresh;
			end
			sdramPkg::initRefresh:
			begin
				initCmd.cmd = sdramPkg::autoRefresh;
				delayLoad = 1'b1;
				delayValue = 16'd2;					// three NOPs behind each refresh
				nextState = sdramPkg::initRefreshNop;
			end
			sdramPkg::initRefreshNop:
				if (delayDone)
					nextState = (refreshCount == '0) ? sdramPkg::initModeSet : sdramPkg::initRefresh;
			sdramPkg::initModeSet:
			begin
				initCmd.cmd = sdramPkg::modeSet;
				initCmd.addr = sdramPkg::modeWord;	// bank 0 selects the base mode register
				delayLoad = 1'b1;
				delayValue = 16'd2;
				nextState = sdramPkg::initModeNop;
			end
			sdramPkg::initModeNop:
				if (delayDone)
					nextState = sdramPkg::initComplete;
			sdramPkg::initComplete:
				nextState = sdramPkg::initComplete;	// parked, access FSM owns the pins
			default:
				nextState = sdramPkg::initPowerUp;
		endcase
	end

endmodule

/* logic/refreshTimer.sv */
// refresh interval timer, raises a refresh request that holds until the refresh is done
`timescale 1ns/1ns

module refreshTimer #(
	parameter sdramPkg::delayT RefreshInterval = 16'd380
) (
	input logic Clock,
	input logic Reset_L,
	input logic initDone,
	input logic refreshReload,		// pulse at the end of each refresh
	output logic refreshDue			// high from timeout until reload
);

	sdramPkg::delayT refreshCount;
	logic initDoneQ;				// for the first rising edge of initDone
	logic reload;

	assign reload = (initDone && !initDoneQ) || refreshReload;

	// parked at zero so a late refresh is never lost
	assign refreshDue = (refreshCount == '0);

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			refreshCount <= RefreshInterval;	// no request before init finishes
			initDoneQ <= 1'b0;
		end
		else
		begin
			initDoneQ <= initDone;
			if (reload)
				refreshCount <= RefreshInterval;
			else if (initDone && !refreshDue)
				refreshCount <= refreshCount - 1'b1;
		end
	end

endmodule

/* logic/sdramController.sv */
// SDRAM controller top level for a 68000 bus and a 32M x16 SDRAM at CAS latency 2
`timescale 1ns/1ns

module sdramController #(
	parameter sdramPkg::delayT PowerUpCycles = 16'd5000,	// 100 us at 50 MHz
	parameter logic [3:0] InitRefreshes = 4'd8,
	parameter sdramPkg::delayT RefreshInterval = 16'd380,	// under 7.8 us per row
	parameter logic [1:0] CasLatency = 2'd2
) (
	input logic Clock,
	input logic Reset_L,
	input sdramPkg::cpuAddrT Address,
	input sdramPkg::wordT DataIn,
	input logic UDS_L,
	input logic LDS_L,
	input logic DramSelect_L,
	input logic WE_L,
	input logic AS_L,
	output sdramPkg::wordT DataOut,
	output logic SDram_CKE_H,
	output logic SDram_CS_L,
	output logic SDram_RAS_L,
	output logic SDram_CAS_L,
	output logic SDram_WE_L,
	output sdramPkg::rowAddrT SDram_Addr,
	output sdramPkg::bankT SDram_BA,
	inout wire sdramPkg::wordT SDram_DQ,
	output logic Dtack_L,
	output logic ResetOut_L
);

	sdramPkg::sdramCmdT initCmd;
	sdramPkg::sdramCmdT accessCmd;
	sdramPkg::cpuReqT cpuReq;
	sdramPkg::wordT writeData;
	logic initDone;
	logic refreshDue;
	logic refreshReload;
	logic writeEnable;
	logic readLatch;
	logic dtack;

	initSequencer #(.PowerUpCycles(PowerUpCycles), .InitRefreshes(InitRefreshes)) init0 (
		.Clock(Clock), .Reset_L(Reset_L), .initCmd(initCmd), .initDone(initDone));

	refreshTimer #(.RefreshInterval(RefreshInterval)) refresh0 (
		.Clock(Clock), .Reset_L(Reset_L), .initDone(initDone),
		.refreshReload(refreshReload), .refreshDue(refreshDue));

	accessFsm #(.CasLatency(CasLatency)) access0 (
		.Clock(Clock), .Reset_L(Reset_L), .initDone(initDone), .refreshDue(refreshDue),
		.cpuReq(cpuReq), .accessCmd(accessCmd), .refreshReload(refreshReload),
		.writeEnable(writeEnable), .readLatch(readLatch), .dtack(dtack),
		.writeData(writeData));

	sdramIo io0 (
		.Clock(Clock), .Reset_L(Reset_L), .Address(Address), .DataIn(DataIn),
		.UDS_L(UDS_L), .LDS_L(LDS_L), .DramSelect_L(DramSelect_L), .WE_L(WE_L), .AS_L(AS_L),
		.initCmd(initCmd), .accessCmd(accessCmd), .initDone(initDone),
		.writeEnable(writeEnable), .writeData(writeData), .readLatch(readLatch),
		.dtack(dtack), .cpuReq(cpuReq), .SDram_CKE_H(SDram_CKE_H), .SDram_CS_L(SDram_CS_L),
		.SDram_RAS_L(SDram_RAS_L), .SDram_CAS_L(SDram_CAS_L), .SDram_WE_L(SDram_WE_L),
		.SDram_Addr(SDram_Addr), .SDram_BA(SDram_BA), .SDram_DQ(SDram_DQ),
		.DataOut(DataOut), .Dtack_L(Dtack_L), .ResetOut_L(ResetOut_L));

endmodule

/* logic/sdramIo.sv */
// pin stage: CPU bus decode, command select, registered SDRAM pins, DQ tristate and read capture
`timescale 1ns/1ns

module sdramIo (
	input logic Clock,
	input logic Reset_L,
	input sdramPkg::cpuAddrT Address,
	input sdramPkg::wordT DataIn,
	input logic UDS_L,
	input logic LDS_L,
	input logic DramSelect_L,
	input logic WE_L,
	input logic AS_L,
	input sdramPkg::sdramCmdT initCmd,
	input sdramPkg::sdramCmdT accessCmd,
	input logic initDone,
	input logic writeEnable,
	input sdramPkg::wordT writeData,
	input logic readLatch,
	input logic dtack,
	output sdramPkg::cpuReqT cpuReq,
	output logic SDram_CKE_H,
	output logic SDram_CS_L,
	output logic SDram_RAS_L,
	output logic SDram_CAS_L,
	output logic SDram_WE_L,
	output sdramPkg::rowAddrT SDram_Addr,
	output sdramPkg::bankT SDram_BA,
	inout wire sdramPkg::wordT SDram_DQ,
	output sdramPkg::wordT DataOut,
	output logic Dtack_L,
	output logic ResetOut_L
);

	sdramPkg::sdramCmdT activeCmd;
	sdramPkg::sdramCmdT pinCmd;		// command as it sits on the pins
	sdramPkg::wordT dqOut;
	logic dqEnable;
	logic readLatchQ;				// capture window lined up with the pins

	assign cpuReq = '{address: Address, dataIn: DataIn, select: !DramSelect_L,
		strobe: !DramSelect_L && !AS_L, dataStrobe: !UDS_L || !LDS_L, write: !WE_L};

	assign activeCmd = initDone ? accessCmd : initCmd;	// init owns the pins first

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			pinCmd <= sdramPkg::powerUpCmd;
			dqEnable <= 1'b0;
			readLatchQ <= 1'b0;
			Dtack_L <= 1'b1;
			ResetOut_L <= 1'b0;			// CPU held in reset through init
		end
		else
		begin
			pinCmd <= activeCmd;
			dqEnable <= writeEnable;
			readLatchQ <= readLatch;
			Dtack_L <= !dtack;
			ResetOut_L <= initDone;
		end
	end

	always_ff @(posedge Clock)
		dqOut <= writeData;

	assign SDram_CKE_H = pinCmd.cke;
	assign {SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} = pinCmd.cmd;
	assign SDram_BA = pinCmd.bank;
	assign SDram_Addr = pinCmd.addr;
	assign SDram_DQ = dqEnable ? dqOut : 'z;		// released unless writing

	// mid cycle sample, the SDRAM output is settled by the falling edge
	always_ff @(negedge Clock)
		if (readLatchQ)
			DataOut <= SDram_DQ;

endmodule

/* logic/sdramPkg.sv */
// shared types, SDRAM command encodings and FSM states for the 68000 SDRAM controller
package sdramPkg;

	////////////////////////////////////////////////////////////////////////////
	// widths that carry a meaning
	////////////////////////////////////////////////////////////////////////////

	typedef logic [31:0] cpuAddrT;		// 68000 address bus
	typedef logic [15:0] wordT;			// CPU data and SDRAM DQ word
	typedef logic [12:0] rowAddrT;		// SDRAM A12..A0, row or column + A10
	typedef logic [1:0] bankT;			// BA1..BA0
	typedef logic [15:0] delayT;		// delay and refresh counters

	// {CS_L, RAS_L, CAS_L, WE_L}, CKE travels separately in the command struct
	typedef enum logic [3:0] {
		deselect = 4'b1111,
		nop = 4'b0111,
		activate = 4'b0011,			// opens the row given on the address pins
		read = 4'b0101,				// A10 high selects auto precharge
		write = 4'b0100,			// A10 high selects auto precharge
		precharge = 4'b0010,		// A10 high closes all banks
		autoRefresh = 4'b0001,
		modeSet = 4'b0000			// mode register load from the address pins
	} sdramCmdE;

	// one command exactly as it lands on the SDRAM pins
	typedef struct packed {
		logic cke;					// clock enable, active high
		sdramCmdE cmd;
		bankT bank;
		rowAddrT addr;
	} sdramCmdT;

	// CPU bus after decoding to active high
	typedef struct packed {
		cpuAddrT address;
		wordT dataIn;
		logic select;				// DramSelect_L low
		logic strobe;				// select with AS_L low
		logic dataStrobe;			// UDS_L or LDS_L low
		logic write;				// WE_L low
	} cpuReqT;

	typedef enum logic [3:0] {
		initPowerUp, initWait, initNop, initPrecharge, initRefresh,
		initRefreshNop, initModeSet, initModeNop, initComplete
	} initStateE;

	typedef enum logic [3:0] {
		accIdle, accRefPrecharge, accRefNop, accRefRefresh, accRefWait,
		accRead, accCasWait, accPreWrite, accPostWrite, accTerminate
	} accessStateE;

	// burst length 1, sequential, CAS latency 2, single location write (A9)
	localparam rowAddrT modeWord = 13'h0220;

	// A10 alone, precharge all banks or auto precharge on read/write
	localparam rowAddrT allBanks = 13'h0400;

	// CKE, CS, RAS, CAS and WE all held low while the device powers up
	localparam sdramCmdT powerUpCmd = '{cke: 1'b0, cmd: modeSet, bank: '0, addr: '0};

endpackage

/* run.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tbSdramController -f files.f \
	-o simv > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1
grep -q "^Verification passed$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
